// File: all.f
design/sensor_frame_pkg.sv
design/frame_ctrl.sv
design/payload_packer.sv
design/accel_energy.sv
design/sensor_frame_top.sv
tests/clk_gen.sv
tests/sensor_frame_asserts.sv
tests/tb_sensor_frame.sv

// File: design/accel_energy.sv
`timescale 1ns/1ps
`default_nettype none

module accel_energy #(
	parameter sensor_frame_pkg::square_sum_t G_THRESHOLD = 32'h0040_0000,
	parameter sensor_frame_pkg::square_sum_t THRESHOLD   = 32'h0010_0000
) (
	input  wire                          clk_50m,
	input  wire                          sys_rst_n,
	input  sensor_frame_pkg::byte_t      rx_byte_i,
	input  wire                          accel_we_i,
	input  wire                          frame_done_i,
	input  sensor_frame_pkg::record_t    record_i,
	output sensor_frame_pkg::frame_out_t frame_o,
	output logic                         frame_valid_o
);

	import sensor_frame_pkg::*;

	localparam int          AXIS_NUM = 3;
	localparam square_sum_t UPPER    = G_THRESHOLD + THRESHOLD;
	localparam square_sum_t LOWER    = G_THRESHOLD - THRESHOLD;

	byte_t       low_byte;
	axis_t       axis_word [AXIS_NUM];
	logic        byte_hi;
	logic [1:0]  axis_idx;
	axis_t       mag_q [AXIS_NUM];
	record_t     record_q;
	logic        stage1_vld;
	square_sum_t square_sum;
	logic        energetic;

	// two's complement absolute value, 0x8000 gives 32768
	function automatic axis_t axis_mag(input axis_t word);
		return word[$bits(axis_t)-1] ? (~word + 1'b1) : word;
	endfunction

	// little-endian words, low byte first
	always_ff @(posedge clk_50m)
	begin
		if (!sys_rst_n)
		begin
			byte_hi  <= 1'b0;
			axis_idx <= '0;
		end
		else if (frame_done_i)
		begin
			byte_hi  <= 1'b0;
			axis_idx <= '0;
		end
		else if (accel_we_i)
		begin
			byte_hi <= !byte_hi;
			if (byte_hi)
				axis_idx <= axis_idx + 1'b1;
		end
	end

	always_ff @(posedge clk_50m)
	begin
		if (accel_we_i && !byte_hi)
			low_byte <= rx_byte_i;
		if (accel_we_i && byte_hi)
			axis_word[axis_idx] <= {rx_byte_i, low_byte};
	end

	// stage 1: magnitudes and a copy of the record
	always_ff @(posedge clk_50m)
	begin
		if (frame_done_i)
		begin
			for (int i = 0; i < AXIS_NUM; i++)
				mag_q[i] <= axis_mag(axis_word[i]);
			record_q <= record_i;
		end
	end

	always_ff @(posedge clk_50m)
	begin
		if (!sys_rst_n)
			stage1_vld <= 1'b0;
		else
			stage1_vld <= frame_done_i;
	end

	// 16-bit magnitudes keep the sum within 32 bits
	assign square_sum = square_sum_t'(mag_q[0]) * square_sum_t'(mag_q[0]) +
	                    square_sum_t'(mag_q[1]) * square_sum_t'(mag_q[1]) +
	                    square_sum_t'(mag_q[2]) * square_sum_t'(mag_q[2]);
	assign energetic  = (square_sum >= UPPER) || (square_sum <= LOWER);

	// stage 2: graded frame out
	always_ff @(posedge clk_50m)
	begin
		if (!sys_rst_n)
		begin
			frame_o       <= '0;
			frame_valid_o <= 1'b0;
		end
		else
		begin
			frame_valid_o <= stage1_vld;
			if (stage1_vld)
			begin
				frame_o.record <= record_q;
				frame_o.energy <= energetic;
			end
		end
	end

endmodule

`default_nettype wire

// File: design/frame_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module frame_ctrl (
	input  wire                     clk_50m,
	input  wire                     sys_rst_n,
	input  sensor_frame_pkg::byte_t rx_byte_i,
	input  wire                     rx_valid_i,
	output logic                    payload_we_o,
	output logic                    accel_we_o,
	output logic                    frame_done_o
);

	import sensor_frame_pkg::*;

	localparam int OFS_W = $clog2(PKT_SIZE);
	localparam int PKT_W = $clog2(PKT_NUM);
	// three axes, two bytes each
	localparam int ACCEL_LAST = PAYLOAD_FIRST + 3 * 2 - 1;

	ctrl_state_t      state_q;
	logic [OFS_W-1:0] offset_q;
	logic [PKT_W-1:0] pkt_q;
	logic             in_payload;
	logic             last_in_pkt;
	logic             last_pkt;

	// offset_q is the position of the byte now on rx_byte_i
	assign in_payload  = (offset_q >= OFS_W'(PAYLOAD_FIRST)) &&
	                     (offset_q <= OFS_W'(PAYLOAD_LAST));
	assign last_in_pkt = (offset_q == OFS_W'(PKT_SIZE - 1));
	assign last_pkt    = (pkt_q == PKT_W'(PKT_NUM - 1));

	assign payload_we_o = rx_valid_i && (state_q == COLLECT) && in_payload;
	assign accel_we_o   = payload_we_o && (pkt_q == PKT_W'(ACCEL_PKT)) &&
	                      (offset_q <= OFS_W'(ACCEL_LAST));

	always_ff @(posedge clk_50m)
	begin
		if (!sys_rst_n)
		begin
			state_q      <= HUNT;
			offset_q     <= '0;
			pkt_q        <= '0;
			frame_done_o <= 1'b0;
		end
		else
		begin
			frame_done_o <= 1'b0;
			if (rx_valid_i)
			begin
				unique case (state_q)
					HUNT:
					begin
						if (rx_byte_i == SYNC_BYTE)
							state_q <= SYNC;
					end
					SYNC:
					begin
						// only the first packet's header is checked
						if (rx_byte_i == FUNC_BYTE)
						begin
							state_q  <= COLLECT;
							offset_q <= OFS_W'(PAYLOAD_FIRST);
							pkt_q    <= '0;
						end
						else if (rx_byte_i != SYNC_BYTE)
						begin
							state_q <= HUNT;
						end
					end
					COLLECT:
					begin
						if (last_in_pkt)
						begin
							offset_q <= '0;
							if (last_pkt)
							begin
								// 44th byte of the frame
								frame_done_o <= 1'b1;
								state_q      <= HUNT;
								pkt_q        <= '0;
							end
							else
							begin
								pkt_q <= pkt_q + 1'b1;
							end
						end
						else
						begin
							offset_q <= offset_q + 1'b1;
						end
					end
					default:
					begin
						state_q <= HUNT;
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: design/payload_packer.sv
`timescale 1ns/1ps
`default_nettype none

module payload_packer (
	input  wire                       clk_50m,
	input  wire                       sys_rst_n,
	input  sensor_frame_pkg::byte_t   rx_byte_i,
	input  wire                       payload_we_i,
	output sensor_frame_pkg::record_t record_o
);

	import sensor_frame_pkg::*;

	localparam int BYTE_W = $bits(byte_t);
	localparam int REC_W  = $bits(record_t);

	// byte shift register, oldest byte ends up in the top byte
	// after 32 writes the whole frame payload is in place
	always_ff @(posedge clk_50m)
	begin
		if (!sys_rst_n)
		begin
			record_o <= '0;
		end
		else if (payload_we_i)
		begin
			record_o <= {record_o[REC_W-BYTE_W-1:0], rx_byte_i};
		end
	end

endmodule

`default_nettype wire

// File: design/sensor_frame_pkg.sv
`default_nettype none

package sensor_frame_pkg;

	// one byte of the sensor stream
	typedef logic [7:0] byte_t;

	// 32 payload bytes of one frame, first kept byte on top
	typedef logic [255:0] record_t;

	// unsigned magnitude of one acceleration axis
	typedef logic [15:0] axis_t;

	// sum of squares and the band limits
	typedef logic [31:0] square_sum_t;

	typedef struct packed {
		record_t record;
		logic    energy;
	} frame_out_t;

	typedef enum logic [1:0] {
		HUNT,
		SYNC,
		COLLECT
	} ctrl_state_t;

	// frame header bytes
	localparam byte_t SYNC_BYTE = 8'h55;
	localparam byte_t FUNC_BYTE = 8'h50;

	// four packets of eleven bytes
	localparam int PKT_SIZE = 11;
	localparam int PKT_NUM  = 4;

	// in-packet offsets that go into the record
	localparam int PAYLOAD_FIRST = 2;
	localparam int PAYLOAD_LAST  = 9;

	// packet that carries the acceleration words
	localparam int ACCEL_PKT = 1;

endpackage

`default_nettype wire

// File: design/sensor_frame_top.sv
`timescale 1ns/1ps
`default_nettype none

module sensor_frame_top #(
	parameter sensor_frame_pkg::square_sum_t G_THRESHOLD = 32'h0040_0000,
	parameter sensor_frame_pkg::square_sum_t THRESHOLD   = 32'h0010_0000
) (
	input  wire                          clk_50m,
	input  wire                          sys_rst_n,
	input  sensor_frame_pkg::byte_t      rx_byte_i,
	input  wire                          rx_valid_i,
	output sensor_frame_pkg::frame_out_t frame_o,
	output logic                         frame_valid_o
);

	import sensor_frame_pkg::*;

	logic    payload_we;
	logic    accel_we;
	logic    frame_done;
	record_t record;

	// sync hunting and byte positions
	frame_ctrl frame_ctrl_inst (
		.clk_50m      (clk_50m),
		.sys_rst_n    (sys_rst_n),
		.rx_byte_i    (rx_byte_i),
		.rx_valid_i   (rx_valid_i),
		.payload_we_o (payload_we),
		.accel_we_o   (accel_we),
		.frame_done_o (frame_done)
	);

	payload_packer payload_packer_inst (
		.clk_50m      (clk_50m),
		.sys_rst_n    (sys_rst_n),
		.rx_byte_i    (rx_byte_i),
		.payload_we_i (payload_we),
		.record_o     (record)
	);

	// energy grading, two cycles behind frame_done
	accel_energy #(
		.G_THRESHOLD (G_THRESHOLD),
		.THRESHOLD   (THRESHOLD)
	) accel_energy_inst (
		.clk_50m       (clk_50m),
		.sys_rst_n     (sys_rst_n),
		.rx_byte_i     (rx_byte_i),
		.accel_we_i    (accel_we),
		.frame_done_i  (frame_done),
		.record_i      (record),
		.frame_o       (frame_o),
		.frame_valid_o (frame_valid_o)
	);

endmodule

`default_nettype wire

// File: tests/clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clk_gen #(
	parameter int PERIOD_NS  = 20,
	parameter int RST_CYCLES = 10
) (
	output logic clk_o,
	output logic rst_n_o
);

	initial
	begin
		clk_o = 1'b0;
		forever
			#(PERIOD_NS / 2) clk_o = ~clk_o;
	end

	// reset released just after an edge, like the other stimulus
	initial
	begin
		rst_n_o = 1'b0;
		repeat (RST_CYCLES)
			@(posedge clk_o);
		#1;
		rst_n_o = 1'b1;
	end

endmodule

`default_nettype wire

// File: tests/sensor_frame_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module sensor_frame_asserts (
	input wire clk_50m,
	input wire sys_rst_n,
	input wire frame_done_i,
	input wire frame_valid_i
);

	// failed assertions so far
	int error_count = 0;

	// output strobe is a single cycle
	single_pulse: assert property (@(posedge clk_50m) disable iff (!sys_rst_n)
		frame_valid_i |=> !frame_valid_i)
	else
	begin
		error_count++;
		$error("frame_valid_o high for two consecutive cycles");
	end

	// two pipeline stages behind frame_done
	done_to_valid: assert property (@(posedge clk_50m) disable iff (!sys_rst_n)
		frame_done_i |-> ##2 frame_valid_i)
	else
	begin
		error_count++;
		$error("frame_valid_o missing two cycles after frame_done");
	end

	valid_from_done: assert property (@(posedge clk_50m) disable iff (!sys_rst_n)
		frame_valid_i |-> $past(frame_done_i, 2))
	else
	begin
		error_count++;
		$error("frame_valid_o without frame_done two cycles before");
	end

	// synchronous reset clears the strobe one edge later
	quiet_in_reset: assert property (@(posedge clk_50m)
		!sys_rst_n |=> !frame_valid_i)
	else
	begin
		error_count++;
		$error("frame_valid_o high during reset");
	end

endmodule

bind sensor_frame_top sensor_frame_asserts sensor_frame_asserts_inst (
	.clk_50m       (clk_50m),
	.sys_rst_n     (sys_rst_n),
	.frame_done_i  (frame_done),
	.frame_valid_i (frame_valid_o)
);

`default_nettype wire

// File: tests/tb_sensor_frame.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sensor_frame;

	import sensor_frame_pkg::*;

	localparam square_sum_t G_THRESHOLD = 32'h0040_0000;
	localparam square_sum_t THRESHOLD   = 32'h0010_0000;
	localparam int CLK_NS      = 20;
	localparam int MAX_GAP     = 4;
	// upper bound on bytes sent over all tests
	localparam int TOTAL_BYTES = 600;
	localparam int MARGIN      = 200;

	logic       clk_50m;
	logic       sys_rst_n;
	byte_t      rx_byte;
	logic       rx_valid;
	frame_out_t frame;
	logic       frame_valid;
	byte_t      payload [32];
	record_t    exp_record;
	logic       exp_energy;
	int         pulse_count = 0;
	int         frame_count = 0;

	clk_gen #(.PERIOD_NS(CLK_NS), .RST_CYCLES(10)) clk_gen_inst (
		.clk_o   (clk_50m),
		.rst_n_o (sys_rst_n)
	);

	sensor_frame_top #(
		.G_THRESHOLD (G_THRESHOLD),
		.THRESHOLD   (THRESHOLD)
	) sensor_frame_top_inst (
		.clk_50m       (clk_50m),
		.sys_rst_n     (sys_rst_n),
		.rx_byte_i     (rx_byte),
		.rx_valid_i    (rx_valid),
		.frame_o       (frame),
		.frame_valid_o (frame_valid)
	);

	// counted mid-cycle where the strobe is stable
	always @(negedge clk_50m)
	begin
		if (frame_valid === 1'b1)
			pulse_count++;
	end

	task automatic check_value(input string test_name, input logic [263:0] expected,
		input logic [263:0] actual);
		if (actual !== expected)
		begin
			$display("FAILED %s: expected %0h, actual %0h", test_name, expected, actual);
			$display("Errors found");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	task automatic step();
		@(posedge clk_50m);
		#1;
	endtask

	task automatic send_byte(input byte_t value, input int gap);
		rx_byte  = value;
		rx_valid = 1'b1;
		step();
		rx_valid = 1'b0;
		repeat (gap)
			step();
	endtask

	// payload byte i sits i bytes below the top
	function automatic record_t pack_record();
		record_t rec;
		rec = '0;
		for (int i = 0; i < 32; i++)
			rec[255 - 8 * i -: 8] = payload[i];
		return rec;
	endfunction

	function automatic logic band_energy(input int x, input int y, input int z);
		longint sum;
		sum = longint'(x) * x + longint'(y) * y + longint'(z) * z;
		return (sum >= longint'(G_THRESHOLD) + THRESHOLD) ||
		       (sum <= longint'(G_THRESHOLD) - THRESHOLD);
	endfunction

	function automatic int rand_axis();
		return int'($urandom_range(65535)) - 32768;
	endfunction

	task automatic send_frame(input int x, input int y, input int z, input int max_gap);
		byte_t stream [$];
		int    gap;
		for (int i = 0; i < 32; i++)
			payload[i] = byte_t'($urandom);
		// axes little-endian at packet 1 offsets 2 to 7
		{payload[ACCEL_PKT * 8 + 1], payload[ACCEL_PKT * 8]}     = x[15:0];
		{payload[ACCEL_PKT * 8 + 3], payload[ACCEL_PKT * 8 + 2]} = y[15:0];
		{payload[ACCEL_PKT * 8 + 5], payload[ACCEL_PKT * 8 + 4]} = z[15:0];
		for (int p = 0; p < PKT_NUM; p++)
		begin
			stream.push_back(SYNC_BYTE);
			stream.push_back(FUNC_BYTE + byte_t'(p));
			for (int k = PAYLOAD_FIRST; k <= PAYLOAD_LAST; k++)
				stream.push_back(payload[p * 8 + k - PAYLOAD_FIRST]);
			// checksum slot is never verified
			stream.push_back(byte_t'($urandom));
		end
		exp_record = pack_record();
		exp_energy = band_energy(x, y, z);
		foreach (stream[i])
		begin
			gap = (i == stream.size() - 1 || max_gap == 0) ? 0 : $urandom_range(max_gap);
			send_byte(stream[i], gap);
		end
	endtask

	// strobe rises on the second edge after the last byte
	task automatic expect_frame(input string test_name);
		step();
		check_value({test_name, " early valid"}, 0, frame_valid);
		step();
		check_value({test_name, " valid"}, 1, frame_valid);
		check_value({test_name, " record"}, exp_record, frame.record);
		check_value({test_name, " energy"}, exp_energy, frame.energy);
		frame_count++;
	endtask

	task automatic check_pulses(input string test_name);
		repeat (3)
			step();
		check_value({test_name, " pulse count"}, frame_count, pulse_count);
	endtask

	task automatic idle_after_reset();
		check_value("reset_idle valid", 0, frame_valid);
		check_value("reset_idle frame", 0, frame);
		// no 0x55 anywhere so no sync can be found
		for (int i = 0; i < 96; i++)
			send_byte((i % 2) ? FUNC_BYTE : byte_t'($urandom_range(8'h54)), 0);
		check_pulses("reset_idle");
		check_value("reset_idle frame after noise", 0, frame);
	endtask

	task automatic single_frame();
		send_frame(rand_axis(), rand_axis(), rand_axis(), 0);
		expect_frame("single_frame");
		check_pulses("single_frame");
	endtask

	task automatic false_starts();
		send_byte(SYNC_BYTE, 0);
		send_byte(8'h12, 0);
		// function byte after a broken header is ignored
		send_byte(FUNC_BYTE, 0);
		send_byte(SYNC_BYTE, 0);
		send_byte(8'h51, 0);
		// run of sync bytes ahead of the real header
		repeat (3)
			send_byte(SYNC_BYTE, 0);
		send_frame(rand_axis(), rand_axis(), rand_axis(), 0);
		expect_frame("false_starts");
		check_pulses("false_starts");
	endtask

	task automatic grade_case(input string test_name, input int x, input int y, input int z,
		input logic flag);
		send_frame(x, y, z, 0);
		expect_frame(test_name);
		check_value({test_name, " band"}, flag, frame.energy);
	endtask

	task automatic energy_grading();
		grade_case("energy_inside", 2048, 0, 0, 1'b0);
		grade_case("energy_near_upper", 2048, 1023, 0, 1'b0);
		grade_case("energy_upper", 2048, 1024, 0, 1'b1);
		grade_case("energy_lower", 1024, 1024, 1024, 1'b1);
		grade_case("energy_negative", -2048, -1024, 0, 1'b1);
		grade_case("energy_min_axis", -32768, 0, 0, 1'b1);
		check_pulses("energy");
	endtask

	task automatic gapped_frames();
		send_frame(rand_axis(), rand_axis(), rand_axis(), MAX_GAP);
		expect_frame("gaps_first");
		send_frame(rand_axis(), rand_axis(), rand_axis(), MAX_GAP);
		expect_frame("gaps_second");
		check_pulses("gaps");
	endtask

	initial
	begin
		#((TOTAL_BYTES * (MAX_GAP + 1) + MARGIN) * CLK_NS);
		$display("timeout: the tests did not finish in the expected time");
		$display("Errors found");
		$fatal(1, "watchdog expired");
	end

	initial
	begin
		rx_byte  = '0;
		rx_valid = 1'b0;
		void'($urandom(42152));
		wait (sys_rst_n === 1'b1);
		step();
		idle_after_reset();
		single_frame();
		false_starts();
		energy_grading();
		gapped_frames();
		if (sensor_frame_top_inst.sensor_frame_asserts_inst.error_count != 0)
		begin
			$display("a bound assertion on the DUT failed during the run");
			$display("Errors found");
			$fatal(1, "assertion failure");
		end
		else
		begin
			$display("No errors");
			$finish;
		end
	end

endmodule

`default_nettype wire
